//--- lock_cfg_pkg.sv
package lock_cfg_pkg;

    // tone tick timing
    localparam int clk_per_tick_default = 12500;  // 50 MHz / 12500 = 4 kHz tick
    localparam int ticks_per_sec = 4000;
    localparam int sec_cnt_w = $clog2(ticks_per_sec);

    // tone channels, indexed by tone_e
    localparam int tone_count = 4;
    localparam int tone_cnt_w = 12;  // holds the longest tone length
    localparam int half_cnt_w = 4;   // holds the longest half period

    // order is success, fail, keypress, tick
    localparam int tone_half_ticks [tone_count] = '{2, 8, 4, 8};
    localparam int tone_len_ticks [tone_count] = '{2400, 1200, 800, 400};

    // silent window, start == end means no gap
    localparam int tone_gap_start [tone_count] = '{0, 400, 0, 0};
    localparam int tone_gap_end [tone_count] = '{0, 800, 0, 0};

    // lockout policy
    localparam int max_tries = 3;

    // bcd seconds per lockout, last entry repeats
    localparam logic [7:0] lock_secs_table [4] = '{
        8'h05,
        8'h10,
        8'h20,
        8'h60
    };

    // code after reset
    localparam logic [11:0] default_code = 12'h246;

endpackage

//--- lock_types_pkg.sv
package lock_types_pkg;

    // key codes, digits carry their own value
    typedef enum logic [3:0] {
        key_0 = 4'h0, key_1 = 4'h1, key_2 = 4'h2, key_3 = 4'h3,
        key_4 = 4'h4, key_5 = 4'h5, key_6 = 4'h6, key_7 = 4'h7,
        key_8 = 4'h8, key_9 = 4'h9,
        key_enter = 4'hA,
        key_set = 4'hB,
        key_clear = 4'hC,
        key_back = 4'hE,
        key_none = 4'hF
    } key_e;

    typedef enum logic [1:0] {
        st_entry,
        st_setmode,
        st_pass,
        st_locked
    } ctrl_state_e;

    // lower index wins in the buzzer mixer
    typedef enum logic [1:0] {
        tone_success = 2'd0,
        tone_fail = 2'd1,
        tone_key = 2'd2,
        tone_tick = 2'd3
    } tone_e;

    // display nibbles
    localparam logic [3:0] nib_blank = 4'hF;
    localparam logic [3:0] nib_dash = 4'hD;
    localparam logic [11:0] pass_pattern = 12'hBCC;

endpackage

//--- keypad_encoder.sv
`timescale 1ns/1ns

module keypad_encoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [15:0]          onehot,
    output lock_types_pkg::key_e key_code,
    output logic                 key_pulse
);

    lock_types_pkg::key_e dec_code;
    lock_types_pkg::key_e prev_code;

    // keypad wiring order, multi-hot and idle fall to none
    always_comb begin
        case (onehot)
            16'h0001: dec_code = lock_types_pkg::key_enter;
            16'h0008: dec_code = lock_types_pkg::key_0;
            16'h0010: dec_code = lock_types_pkg::key_set;
            16'h0020: dec_code = lock_types_pkg::key_3;
            16'h0040: dec_code = lock_types_pkg::key_2;
            16'h0080: dec_code = lock_types_pkg::key_1;
            16'h0100: dec_code = lock_types_pkg::key_clear;
            16'h0200: dec_code = lock_types_pkg::key_6;
            16'h0400: dec_code = lock_types_pkg::key_5;
            16'h0800: dec_code = lock_types_pkg::key_4;
            16'h1000: dec_code = lock_types_pkg::key_back;
            16'h2000: dec_code = lock_types_pkg::key_9;
            16'h4000: dec_code = lock_types_pkg::key_8;
            16'h8000: dec_code = lock_types_pkg::key_7;
            default:  dec_code = lock_types_pkg::key_none;  // lines 1, 2 unused
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            key_code <= lock_types_pkg::key_none;
            prev_code <= lock_types_pkg::key_none;
            key_pulse <= 1'b0;
        end else begin
            key_code <= dec_code;
            prev_code <= key_code;
            // one pulse per press, a held key stays quiet
            key_pulse <= (key_code != prev_code) &&
                         (key_code != lock_types_pkg::key_none);
        end
    end

endmodule

//--- code_entry.sv
`timescale 1ns/1ns

module code_entry (
    input  logic                 clk,
    input  logic                 rst,
    input  lock_types_pkg::key_e key_code,
    input  logic                 key_pulse,
    input  logic                 entry_en,
    input  logic                 entry_clear,
    output logic [11:0]          digits,
    output logic [1:0]           digit_count
);

    logic is_digit;
    logic is_back;
    logic can_shift;
    logic can_back;

    assign is_digit = (key_code <= lock_types_pkg::key_9);
    assign is_back = (key_code == lock_types_pkg::key_back);

    // saturate at three digits
    assign can_shift = key_pulse && entry_en && is_digit && (digit_count != 2'd3);
    assign can_back = key_pulse && entry_en && is_back && (digit_count != 2'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            digits <= {3{lock_types_pkg::nib_blank}};
            digit_count <= 2'd0;
        end else if (entry_clear) begin
            digits <= {3{lock_types_pkg::nib_blank}};  // clear wins over any key
            digit_count <= 2'd0;
        end else if (can_shift) begin
            digits <= {digits[7:0], 4'(key_code)};  // newest on the right
            digit_count <= digit_count + 2'd1;
        end else if (can_back) begin
            digits <= {lock_types_pkg::nib_blank, digits[11:4]};  // drop newest
            digit_count <= digit_count - 2'd1;
        end
    end

endmodule

//--- lock_controller.sv
`timescale 1ns/1ns

module lock_controller (
    input  logic                 clk,
    input  logic                 rst,
    input  lock_types_pkg::key_e key_code,
    input  logic                 key_pulse,
    input  logic [11:0]          digits,
    input  logic [1:0]           digit_count,
    input  logic [7:0]           lock_bcd,
    input  logic                 lock_done,
    output logic                 entry_en,
    output logic                 entry_clear,
    output logic [11:0]          display,
    output logic [1:0]           tries,
    output logic                 locked,
    output logic [2:0]           tone_start,
    output logic                 lock_start,
    output logic [7:0]           lock_secs
);

    lock_types_pkg::ctrl_state_e state;
    logic [11:0] code;
    logic [1:0]  lock_cnt;  // lockouts so far, saturates at 3
    logic        live_key;
    logic        enter_ok;
    logic        do_store;
    logic        do_match;
    logic        do_miss;
    logic        do_lock;
    logic        key_tone;

    assign entry_en = (state == lock_types_pkg::st_entry) ||
                      (state == lock_types_pkg::st_setmode);
    assign locked = (state == lock_types_pkg::st_locked);
    assign live_key = key_pulse && !locked;

    // enter only counts with a full entry
    assign enter_ok = key_pulse && entry_en && (digit_count == 2'd3) &&
                      (key_code == lock_types_pkg::key_enter);
    assign do_store = enter_ok && (state == lock_types_pkg::st_setmode);
    assign do_match = enter_ok && (state == lock_types_pkg::st_entry) && (digits == code);
    assign do_miss = enter_ok && (state == lock_types_pkg::st_entry) && (digits != code);
    assign do_lock = do_miss && (tries == 2'(lock_cfg_pkg::max_tries - 1));
    assign key_tone = key_pulse && entry_en &&
                      ((key_code <= lock_types_pkg::key_9) ||
                       (key_code == lock_types_pkg::key_back));

    // same cycle as the key so the entry clears with the rest
    assign entry_clear = (live_key && (key_code == lock_types_pkg::key_clear)) ||
                         (key_pulse && entry_en && (key_code == lock_types_pkg::key_set)) ||
                         do_store || do_miss;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lock_types_pkg::st_entry;
            code <= lock_cfg_pkg::default_code;
            tries <= 2'd0;
            lock_cnt <= 2'd0;
            tone_start <= 3'b000;
            lock_start <= 1'b0;
        end else begin
            tone_start <= 3'b000;
            lock_start <= do_lock;
            tone_start[lock_types_pkg::tone_key] <= key_tone;
            if (locked) begin
                if (lock_done)
                    state <= lock_types_pkg::st_entry;  // keys ignored until done
            end else if (live_key && (key_code == lock_types_pkg::key_clear)) begin
                state <= lock_types_pkg::st_entry;  // also cancels set mode
                tries <= 2'd0;
            end else if (key_pulse && entry_en && (key_code == lock_types_pkg::key_set)) begin
                state <= lock_types_pkg::st_setmode;
            end else if (do_store) begin
                code <= digits;
                state <= lock_types_pkg::st_entry;
                tries <= 2'd0;
                tone_start[lock_types_pkg::tone_success] <= 1'b1;
            end else if (do_match) begin
                state <= lock_types_pkg::st_pass;
                tone_start[lock_types_pkg::tone_success] <= 1'b1;
            end else if (do_miss) begin
                tone_start[lock_types_pkg::tone_fail] <= 1'b1;
                if (do_lock) begin
                    tries <= 2'd0;
                    state <= lock_types_pkg::st_locked;
                    if (lock_cnt != 2'd3)
                        lock_cnt <= lock_cnt + 2'd1;
                end else begin
                    tries <= tries + 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_lock)
            lock_secs <= lock_cfg_pkg::lock_secs_table[lock_cnt];  // before advance
    end

    always_comb begin
        display = digits;
        case (state)
            lock_types_pkg::st_pass:   display = lock_types_pkg::pass_pattern;
            lock_types_pkg::st_locked: display = {lock_types_pkg::nib_blank, lock_bcd};
            lock_types_pkg::st_setmode: begin
                for (int i = 0; i < 3; i++) begin
                    if (digits[i*4 +: 4] == lock_types_pkg::nib_blank)
                        display[i*4 +: 4] = lock_types_pkg::nib_dash;  // empty slots dashed
                end
            end
            default: display = digits;
        endcase
    end

endmodule

//--- lockout_timer.sv
`timescale 1ns/1ns

module lockout_timer #(
    parameter int clk_per_tick = lock_cfg_pkg::clk_per_tick_default
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       lock_start,
    input  logic [7:0] lock_secs,
    output logic       tick,
    output logic       sec_pulse,
    output logic [7:0] lock_bcd,
    output logic       lock_done
);

    localparam int div_w = $clog2(clk_per_tick + 1);
    localparam int sec_w = lock_cfg_pkg::sec_cnt_w;

    logic [div_w-1:0] div_cnt;
    logic [sec_w-1:0] sec_cnt;
    logic             run;
    logic             sec_evt;

    // free running tone tick
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick <= 1'b0;
        end else if (div_cnt == div_w'(clk_per_tick - 1)) begin
            div_cnt <= '0;
            tick <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    assign sec_evt = run && tick && (lock_bcd != 8'h00) &&
                     (sec_cnt == sec_w'(lock_cfg_pkg::ticks_per_sec - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
            sec_cnt <= '0;
            lock_bcd <= 8'h00;
            sec_pulse <= 1'b0;
            lock_done <= 1'b0;
        end else begin
            sec_pulse <= sec_evt;
            lock_done <= 1'b0;
            if (lock_start) begin
                run <= 1'b1;
                sec_cnt <= '0;
                lock_bcd <= lock_secs;
            end else if (run && (lock_bcd == 8'h00)) begin
                run <= 1'b0;  // one cycle after reaching 00
                lock_done <= 1'b1;
            end else if (sec_evt) begin
                sec_cnt <= '0;
                if (lock_bcd[3:0] == 4'h0)
                    lock_bcd <= {lock_bcd[7:4] - 4'h1, 4'h9};  // borrow from tens
                else
                    lock_bcd[3:0] <= lock_bcd[3:0] - 4'h1;
            end else if (run && tick) begin
                sec_cnt <= sec_cnt + 1'b1;
            end
        end
    end

endmodule

//--- tone_channel.sv
`timescale 1ns/1ns

module tone_channel #(
    parameter int chan = 0
) (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic start,
    output logic wave,
    output logic active
);

    localparam int half = lock_cfg_pkg::tone_half_ticks[chan];
    localparam int len = lock_cfg_pkg::tone_len_ticks[chan];
    localparam int gap_s = lock_cfg_pkg::tone_gap_start[chan];
    localparam int gap_e = lock_cfg_pkg::tone_gap_end[chan];
    localparam int len_w = lock_cfg_pkg::tone_cnt_w;
    localparam int half_w = lock_cfg_pkg::half_cnt_w;

    logic [len_w-1:0]  len_cnt;
    logic [half_w-1:0] half_cnt;
    logic              phase;
    logic              in_gap;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            phase <= 1'b0;
            len_cnt <= '0;
            half_cnt <= '0;
        end else if (start) begin
            active <= 1'b1;  // restart even if already playing
            phase <= 1'b1;
            len_cnt <= '0;
            half_cnt <= '0;
        end else if (active && tick) begin
            if (len_cnt == len_w'(len - 1)) begin
                active <= 1'b0;
                phase <= 1'b0;
            end else begin
                len_cnt <= len_cnt + 1'b1;
                if (half_cnt == half_w'(half - 1)) begin
                    half_cnt <= '0;
                    phase <= ~phase;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

    assign in_gap = (int'(len_cnt) >= gap_s) && (int'(len_cnt) < gap_e);
    assign wave = phase && !in_gap;  // silent inside the gap

endmodule

//--- buzzer_mixer.sv
`timescale 1ns/1ns

module buzzer_mixer (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [lock_cfg_pkg::tone_count-1:0] waves,
    input  logic [lock_cfg_pkg::tone_count-1:0] actives,
    output logic                                buzzer
);

    logic sel_wave;

    // scan down so the lowest active index wins
    always_comb begin
        sel_wave = 1'b0;
        for (int i = lock_cfg_pkg::tone_count - 1; i >= 0; i--) begin
            if (actives[i])
                sel_wave = waves[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            buzzer <= 1'b0;
        else
            buzzer <= sel_wave;  // quiet when nothing active
    end

endmodule

//--- lock_top.sv
`timescale 1ns/1ns

module lock_top #(
    parameter int clk_per_tick = lock_cfg_pkg::clk_per_tick_default
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] onehot,
    output logic [11:0] display,
    output logic [1:0]  digit_count,
    output logic [1:0]  tries,
    output logic        locked,
    output logic        buzzer
);

    lock_types_pkg::key_e key_code;
    logic        key_pulse;
    logic        entry_en;
    logic        entry_clear;
    logic [11:0] digits;
    logic [2:0]  tone_start;
    logic        lock_start;
    logic [7:0]  lock_secs;
    logic        tick;
    logic        sec_pulse;
    logic [7:0]  lock_bcd;
    logic        lock_done;
    logic [lock_cfg_pkg::tone_count-1:0] starts;
    logic [lock_cfg_pkg::tone_count-1:0] waves;
    logic [lock_cfg_pkg::tone_count-1:0] actives;

    assign starts[2:0] = tone_start;
    assign starts[lock_types_pkg::tone_tick] = sec_pulse;  // one tick tone per second

    keypad_encoder keypad_encoder_inst (
        .clk(clk), .rst(rst), .onehot(onehot),
        .key_code(key_code), .key_pulse(key_pulse)
    );

    code_entry code_entry_inst (
        .clk(clk), .rst(rst), .key_code(key_code), .key_pulse(key_pulse),
        .entry_en(entry_en), .entry_clear(entry_clear),
        .digits(digits), .digit_count(digit_count)
    );

    lock_controller lock_controller_inst (
        .clk(clk), .rst(rst), .key_code(key_code), .key_pulse(key_pulse),
        .digits(digits), .digit_count(digit_count),
        .lock_bcd(lock_bcd), .lock_done(lock_done),
        .entry_en(entry_en), .entry_clear(entry_clear),
        .display(display), .tries(tries), .locked(locked),
        .tone_start(tone_start), .lock_start(lock_start), .lock_secs(lock_secs)
    );

    lockout_timer #(.clk_per_tick(clk_per_tick)) lockout_timer_inst (
        .clk(clk), .rst(rst), .lock_start(lock_start), .lock_secs(lock_secs),
        .tick(tick), .sec_pulse(sec_pulse), .lock_bcd(lock_bcd), .lock_done(lock_done)
    );

    for (genvar g = 0; g < lock_cfg_pkg::tone_count; g++) begin : g_tone
        tone_channel #(.chan(g)) tone_channel_inst (
            .clk(clk), .rst(rst), .tick(tick), .start(starts[g]),
            .wave(waves[g]), .active(actives[g])
        );
    end

    buzzer_mixer buzzer_mixer_inst (
        .clk(clk), .rst(rst), .waves(waves), .actives(actives), .buzzer(buzzer)
    );

endmodule

//--- tb_lock_top.sv
`timescale 1ns/1ns

module tb_lock_top;

    localparam int tick_div = 2;  // short seconds for simulation
    localparam int cyc_per_sec = lock_cfg_pkg::ticks_per_sec * tick_div;
    localparam int tone_cycles = lock_cfg_pkg::tone_len_ticks[0] * tick_div;
    localparam int gap_lo_cycles = lock_cfg_pkg::tone_gap_start[1] * tick_div;
    localparam int gap_cycles = (lock_cfg_pkg::tone_gap_end[1] -
                                 lock_cfg_pkg::tone_gap_start[1]) * tick_div;
    localparam int key_tone_cycles = 4 + tick_div + 2;  // press to first buzzer high
    localparam int lock_secs_used = 5 + 10;  // first two lockouts
    localparam int watchdog_cycles = lock_secs_used * cyc_per_sec + 8 * tone_cycles + 20000;

    logic        clk;
    logic        rst;
    logic [15:0] onehot;
    logic [11:0] display;
    logic [1:0]  digit_count;
    logic [1:0]  tries;
    logic        locked;
    logic        buzzer;

    integer      seed = 32'h707e;
    int          errors;
    int          test_errors;
    int          tests_run;
    string       test_name;
    logic [11:0] current_code;

    lock_top #(.clk_per_tick(tick_div)) lock_top_inst (
        .clk(clk), .rst(rst), .onehot(onehot), .display(display),
        .digit_count(digit_count), .tries(tries), .locked(locked), .buzzer(buzzer)
    );

    always #10 clk = ~clk;

    // keypad line for each key
    function automatic logic [15:0] key_line(input logic [3:0] key);
        case (key)
            lock_types_pkg::key_enter: key_line = 16'h0001;
            lock_types_pkg::key_0:     key_line = 16'h0008;
            lock_types_pkg::key_set:   key_line = 16'h0010;
            lock_types_pkg::key_3:     key_line = 16'h0020;
            lock_types_pkg::key_2:     key_line = 16'h0040;
            lock_types_pkg::key_1:     key_line = 16'h0080;
            lock_types_pkg::key_clear: key_line = 16'h0100;
            lock_types_pkg::key_6:     key_line = 16'h0200;
            lock_types_pkg::key_5:     key_line = 16'h0400;
            lock_types_pkg::key_4:     key_line = 16'h0800;
            lock_types_pkg::key_back:  key_line = 16'h1000;
            lock_types_pkg::key_9:     key_line = 16'h2000;
            lock_types_pkg::key_8:     key_line = 16'h4000;
            lock_types_pkg::key_7:     key_line = 16'h8000;
            default:                   key_line = 16'h0000;
        endcase
    endfunction

    // bcd seconds minus one, via binary
    function automatic logic [7:0] bcd_decrement(input logic [7:0] v);
        int n;
        n = v[7:4] * 10 + v[3:0] - 1;
        bcd_decrement = {4'(n / 10), 4'(n % 10)};
    endfunction

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        errors += test_errors;
        $display("test %s finished with %0d errors", test_name, test_errors);
    endtask

    task automatic check_value(input string what, input logic [11:0] expected,
                               input logic [11:0] actual);
        assert (actual === expected)
        else begin
            $display("[ERROR] %s: %s expected %h, actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic check_outputs(input logic [11:0] exp_disp, input logic [1:0] exp_count,
                                 input logic [1:0] exp_tries);
        check_value("display", exp_disp, display);
        check_value("digit_count", exp_count, digit_count);
        check_value("tries", exp_tries, tries);
    endtask

    // hold 4 cycles, release 4 cycles
    task automatic press_lines(input logic [15:0] lines);
        onehot = lines;
        repeat (4) @(negedge clk);
        onehot = '0;
        repeat (4) @(negedge clk);
    endtask

    task automatic press_key(input logic [3:0] key);
        press_lines(key_line(key));
    endtask

    task automatic enter_digits(input logic [11:0] code);
        press_key(code[11:8]);
        press_key(code[7:4]);
        press_key(code[3:0]);
    endtask

    task automatic wait_buzzer_high(input int max_cycles, output bit seen);
        int n;
        n = 0;
        seen = 0;
        while (!seen && n < max_cycles) begin
            @(negedge clk);
            n++;
            if (buzzer === 1'b1)
                seen = 1;
        end
    endtask

    // digit press that also expects the keypress tone
    task automatic press_with_key_tone(input logic [3:0] key);
        bit seen;
        fork
            press_key(key);
            wait_buzzer_high(key_tone_cycles, seen);
        join
        assert (seen) else report_failure("no keypress tone on the buzzer after a digit key");
    endtask

    task automatic pick_wrong_code(input logic [11:0] avoid, output logic [11:0] code);
        code = avoid;
        while (code == avoid) begin
            for (int i = 0; i < 3; i++)
                code[i*4 +: 4] = 4'($unsigned($random(seed)) % 10);
        end
    endtask

    task automatic count_buzzer_edges(input int cycles, output int edges);
        logic last;
        edges = 0;
        last = buzzer;
        repeat (cycles) begin
            @(negedge clk);
            if (buzzer !== last)
                edges++;
            last = buzzer;
        end
    endtask

    task automatic check_buzzer_quiet(input int cycles);
        int highs;
        highs = 0;
        repeat (cycles) begin
            @(negedge clk);
            if (buzzer !== 1'b0)
                highs++;
        end
        assert (highs == 0)
        else report_failure($sformatf("buzzer was high in %0d cycles of the fail gap", highs));
    endtask

    task automatic enter_wrong_code(input bit check_gap);
        logic [11:0] code;
        pick_wrong_code(current_code, code);
        enter_digits(code);
        press_key(lock_types_pkg::key_enter);
        if (check_gap) begin
            repeat (gap_lo_cycles + 16) @(negedge clk);  // into the silent window
            check_buzzer_quiet(gap_cycles - 40);
        end
    endtask

    task automatic wait_display_change(input int max_cycles, output bit timed_out);
        logic [11:0] last;
        int n;
        last = display;
        n = 0;
        while (display === last && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        timed_out = (display === last);
    endtask

    // one display step per second down to 00, then release
    task automatic follow_countdown(input logic [7:0] secs);
        logic [7:0] expected;
        bit timed_out;
        int n;
        expected = secs;
        while (expected != 8'h00) begin
            wait_display_change(cyc_per_sec + 100, timed_out);
            if (timed_out) begin
                report_failure("display stopped counting down during the lockout");
                expected = 8'h00;
            end else begin
                expected = bcd_decrement(expected);
                check_value("countdown", {4'hF, expected}, display);
            end
        end
        n = 0;
        while (locked && n < 100) begin
            @(negedge clk);
            n++;
        end
        assert (!locked) else report_failure("lock was not released after the countdown");
    endtask

    task automatic test_entry_back();
        start_test("entry_back");
        check_outputs(12'hFFF, 2'd0, 2'd0);
        check_value("locked", 1'b0, locked);
        check_value("buzzer", 1'b0, buzzer);
        press_with_key_tone(lock_types_pkg::key_1);
        press_key(lock_types_pkg::key_2);
        press_key(lock_types_pkg::key_3);
        check_outputs(12'h123, 2'd3, 2'd0);
        press_key(lock_types_pkg::key_4);  // fourth digit is dropped
        check_outputs(12'h123, 2'd3, 2'd0);
        press_key(lock_types_pkg::key_back);
        check_outputs(12'hF12, 2'd2, 2'd0);
        press_key(lock_types_pkg::key_clear);
        check_outputs(12'hFFF, 2'd0, 2'd0);
        finish_test();
    endtask

    task automatic test_correct_code();
        int edges;
        int expected_edges;
        start_test("correct_code");
        expected_edges = lock_cfg_pkg::tone_len_ticks[0] / lock_cfg_pkg::tone_half_ticks[0];
        enter_digits(12'h246);
        fork
            press_key(lock_types_pkg::key_enter);
            count_buzzer_edges(tone_cycles + 40, edges);
        join
        check_value("display", 12'hBCC, display);
        assert (edges >= expected_edges - 1 && edges <= expected_edges + 1)
        else begin
            $display("[ERROR] %s: buzzer edges expected %0d, actual %0d",
                     test_name, expected_edges, edges);
            test_errors++;
        end
        press_key(lock_types_pkg::key_1);
        press_key(lock_types_pkg::key_5);
        check_value("display", 12'hBCC, display);
        press_key(lock_types_pkg::key_clear);
        check_outputs(12'hFFF, 2'd0, 2'd0);
        finish_test();
    endtask

    task automatic test_wrong_code();
        start_test("wrong_code");
        enter_wrong_code(1'b1);
        check_outputs(12'hFFF, 2'd0, 2'd1);
        enter_wrong_code(1'b1);
        check_outputs(12'hFFF, 2'd0, 2'd2);
        finish_test();
    endtask

    task automatic test_lockout();
        start_test("lockout");
        enter_wrong_code(1'b0);  // third miss in a row
        check_outputs(12'hF05, 2'd0, 2'd0);
        check_value("locked", 1'b1, locked);
        press_key(lock_types_pkg::key_1);
        press_key(lock_types_pkg::key_clear);
        check_outputs(12'hF05, 2'd0, 2'd0);
        check_value("locked", 1'b1, locked);
        follow_countdown(8'h05);
        check_outputs(12'hFFF, 2'd0, 2'd0);
        enter_wrong_code(1'b0);
        check_value("tries", 2'd1, tries);
        enter_wrong_code(1'b0);
        check_value("tries", 2'd2, tries);
        enter_wrong_code(1'b0);
        check_outputs(12'hF10, 2'd0, 2'd0);  // second lockout is longer
        check_value("locked", 1'b1, locked);
        follow_countdown(8'h10);
        check_outputs(12'hFFF, 2'd0, 2'd0);
        finish_test();
    endtask

    task automatic test_set_mode();
        start_test("set_mode");
        press_key(lock_types_pkg::key_set);
        check_value("display", 12'hDDD, display);
        enter_digits(12'h789);
        check_value("display", 12'h789, display);
        press_key(lock_types_pkg::key_enter);
        check_outputs(12'hFFF, 2'd0, 2'd0);
        current_code = 12'h789;
        enter_digits(12'h246);  // old code now rejected
        press_key(lock_types_pkg::key_enter);
        check_outputs(12'hFFF, 2'd0, 2'd1);
        enter_digits(12'h789);
        press_key(lock_types_pkg::key_enter);
        check_value("display", 12'hBCC, display);
        press_key(lock_types_pkg::key_clear);
        check_outputs(12'hFFF, 2'd0, 2'd0);
        finish_test();
    endtask

    task automatic test_short_enter();
        start_test("short_enter");
        enter_wrong_code(1'b0);
        check_outputs(12'hFFF, 2'd0, 2'd1);
        press_key(lock_types_pkg::key_1);
        press_key(lock_types_pkg::key_2);
        check_outputs(12'hF12, 2'd2, 2'd1);
        press_key(lock_types_pkg::key_enter);
        check_outputs(12'hF12, 2'd2, 2'd1);
        press_lines(key_line(lock_types_pkg::key_1) | key_line(lock_types_pkg::key_2));
        check_outputs(12'hF12, 2'd2, 2'd1);
        press_lines(key_line(lock_types_pkg::key_3) | key_line(lock_types_pkg::key_enter));
        check_outputs(12'hF12, 2'd2, 2'd1);
        press_key(lock_types_pkg::key_clear);
        check_outputs(12'hFFF, 2'd0, 2'd0);
        finish_test();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        onehot = '0;
        errors = 0;
        tests_run = 0;
        current_code = 12'h246;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        test_entry_back();
        test_correct_code();
        test_wrong_code();
        test_lockout();
        test_set_mode();
        test_short_enter();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    // bounded by the lockout seconds plus tone lengths
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests completed",
                 watchdog_cycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- compile.f
lock_cfg_pkg.sv
lock_types_pkg.sv
keypad_encoder.sv
code_entry.sv
lock_controller.sv
lockout_timer.sv
tone_channel.sv
buzzer_mixer.sv
lock_top.sv
tb_lock_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the lock testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_lock_top -f compile.f -o sim_lock \
    && ./obj_dir/sim_lock > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }

cat sim.log

grep -q "Finished with errors" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
